//--- Makefile
# Verilator build and run of the PL scrambler testbench.

SIM  := obj_dir/Vtb_pls_scrambler
SRCS := $(shell grep -v '^+' pls_scrambler_top.f) sim/pls_tb_checks.svh

.PHONY: all run clean

all: run

$(SIM): pls_scrambler_top.f $(SRCS)
	verilator --binary --assert --timescale 1ns/100ps \
		-f pls_scrambler_top.f --top-module tb_pls_scrambler \
		-Mdir obj_dir -o Vtb_pls_scrambler

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- pls_scrambler_top.f
+incdir+sim
src/pls_sample_pkg.sv
src/pls_code_pkg.sv
src/pls_code_gen.sv
src/pls_sample_align.sv
src/pls_rotator.sv
src/pls_scrambler_top.sv
sim/tb_pls_scrambler.sv

//--- sim/pls_tb_checks.svh
`ifndef PLS_TB_CHECKS_SVH
`define PLS_TB_CHECKS_SVH
`default_nettype none

// rn from an x/y state pair.
function automatic pls_code_pkg::code_t gold_code(input pls_code_pkg::lfsr_t x,
		input pls_code_pkg::lfsr_t y);
	logic b0;
	logic b1;
	b0 = x[0] ^ y[0];
	b1 = x[4] ^ x[6] ^ x[15] ^ y[5] ^ y[6] ^ y[8];
	for (int i = 9; i <= 15; i++) begin
		b1 = b1 ^ y[i];
	end
	return {b1, b0};
endfunction

function automatic pls_sample_pkg::sample_t negate(input pls_sample_pkg::sample_t v);
	return ~v + 16'sd1; // -32768 stays -32768.
endfunction

function automatic pls_sample_pkg::sample_t rot_re(input pls_code_pkg::code_t c,
		input pls_sample_pkg::sample_t re, input pls_sample_pkg::sample_t im);
	case (c)
		pls_code_pkg::CODE_J:     return negate(im);
		pls_code_pkg::CODE_NEG:   return negate(re);
		pls_code_pkg::CODE_NEG_J: return im;
		default:                  return re;
	endcase
endfunction

function automatic pls_sample_pkg::sample_t rot_im(input pls_code_pkg::code_t c,
		input pls_sample_pkg::sample_t re, input pls_sample_pkg::sample_t im);
	case (c)
		pls_code_pkg::CODE_J:     return re;
		pls_code_pkg::CODE_NEG:   return negate(im);
		pls_code_pkg::CODE_NEG_J: return negate(re);
		default:                  return im;
	endcase
endfunction

function automatic pls_sample_pkg::sample_t rand_sample();
	return pls_sample_pkg::sample_t'($random(seed));
endfunction

task automatic reset_model();
	model_x = '0;
	model_y = '0;
	q_re.delete();
	q_im.delete();
	q_scr.delete();
	q_frame.delete();
	q_code.delete();
	repeat (2) begin // aligner stages hold zero after reset.
		q_re.push_back(pls_sample_pkg::SAMPLE_ZERO);
		q_im.push_back(pls_sample_pkg::SAMPLE_ZERO);
		q_scr.push_back(1'b0);
		q_frame.push_back(1'b0);
		q_code.push_back(pls_code_pkg::CODE_PASS);
	end
	last_re = pls_sample_pkg::SAMPLE_ZERO;
	last_im = pls_sample_pkg::SAMPLE_ZERO;
	last_oe = 1'b0;
endtask

task automatic check_sample(input string name, input pls_sample_pkg::sample_t got,
		input pls_sample_pkg::sample_t exp);
	if (got !== exp) begin
		$display("** Error: %s = 0x%h, expected 0x%h (cycle %0d)", name, got, exp, cycle_cnt);
		sample_errs++;
	end
endtask

// works the code back out of the output and compares it.
task automatic check_code(input pls_code_pkg::code_t exp, input pls_sample_pkg::sample_t re,
		input pls_sample_pkg::sample_t im);
	pls_code_pkg::code_t got;
	logic                found;
	found = 1'b0;
	got   = exp;
	if (symbol_re_out === rot_re(exp, re, im) && symbol_im_out === rot_im(exp, re, im)) begin
		return;
	end
	for (int c = 0; c < 4; c++) begin
		if (!found && symbol_re_out === rot_re(pls_code_pkg::code_t'(c), re, im)
				&& symbol_im_out === rot_im(pls_code_pkg::code_t'(c), re, im)) begin
			got   = pls_code_pkg::code_t'(c);
			found = 1'b1;
		end
	end
	if (found) begin
		$display("** Error: code = 0x%h, expected 0x%h (cycle %0d)", got, exp, cycle_cnt);
		code_errs++;
	end else begin
		$display("output (0x%h, 0x%h) is no quadrant rotation of input (0x%h, 0x%h), cycle %0d",
			symbol_re_out, symbol_im_out, re, im, cycle_cnt);
		other_errs++;
	end
endtask

task automatic check_oe(input logic got, input logic exp);
	if (got !== exp) begin
		$display("** Error: oe = 0x%h, expected 0x%h (cycle %0d)", got, exp, cycle_cnt);
		oe_errs++;
	end
endtask

// one clock cycle with the given inputs, then the output check.
task automatic apply(input logic en, input logic init, input logic scr, input logic frame,
		input pls_sample_pkg::sample_t re, input pls_sample_pkg::sample_t im);
	pls_code_pkg::code_t     c;
	pls_code_pkg::code_t     exp_c;
	pls_sample_pkg::sample_t sent_re;
	pls_sample_pkg::sample_t sent_im;
	c = pls_code_pkg::CODE_PASS;
	fs_en = en;
	init_vld = init;
	scrambler_vld = scr;
	frame_vld = frame;
	re_in = re;
	im_in = im;
	if (en) begin
		if (init) begin
			model_x = X_SEED;
			model_y = pls_code_pkg::Y_LOAD;
		end
		if (scr) begin
			c = gold_code(model_x, model_y);
			model_x = {model_x[0] ^ model_x[7], model_x[17:1]};
			model_y = {model_y[0] ^ model_y[5] ^ model_y[7] ^ model_y[10], model_y[17:1]};
		end
		q_re.push_back(re);
		q_im.push_back(im);
		q_scr.push_back(scr);
		q_frame.push_back(frame);
		q_code.push_back(c);
	end
	@(posedge sys_clk);
	@(negedge sys_clk);
	if (en) begin
		exp_c   = q_code.pop_front();
		sent_re = q_re.pop_front();
		sent_im = q_im.pop_front();
		if (q_scr.pop_front()) begin
			check_code(exp_c, sent_re, sent_im);
			last_re = rot_re(exp_c, sent_re, sent_im);
			last_im = rot_im(exp_c, sent_re, sent_im);
		end else begin
			check_sample("symbol_re_out", symbol_re_out, sent_re);
			check_sample("symbol_im_out", symbol_im_out, sent_im);
			last_re = sent_re;
			last_im = sent_im;
		end
		last_oe = q_frame.pop_front();
		check_oe(oe, last_oe);
	end else begin
		check_sample("symbol_re_out", symbol_re_out, last_re);
		check_sample("symbol_im_out", symbol_im_out, last_im);
		check_oe(oe, last_oe);
	end
endtask

task automatic test_reset();
	check_sample("symbol_re_out", symbol_re_out, pls_sample_pkg::SAMPLE_ZERO);
	check_sample("symbol_im_out", symbol_im_out, pls_sample_pkg::SAMPLE_ZERO);
	check_oe(oe, 1'b0);
	repeat (4) apply(1'b0, 1'b1, 1'b1, 1'b1, rand_sample(), rand_sample());
	repeat (6) apply(1'b1, 1'b0, 1'b0, 1'b0, pls_sample_pkg::SAMPLE_ZERO,
		pls_sample_pkg::SAMPLE_ZERO);
endtask

task automatic test_latency();
	int pulses;
	pulses = 0;
	apply(1'b1, 1'b0, 1'b0, 1'b1, rand_sample(), rand_sample());
	pulses += int'(oe);
	repeat (8) begin
		apply(1'b1, 1'b0, 1'b0, 1'b0, pls_sample_pkg::SAMPLE_ZERO, pls_sample_pkg::SAMPLE_ZERO);
		pulses += int'(oe);
	end
	if (pulses != 1) begin
		$display("one frame_vld tick gave %0d oe pulses instead of one", pulses);
		other_errs++;
	end
endtask

task automatic test_scramble();
	pls_sample_pkg::sample_t re;
	pls_sample_pkg::sample_t im;
	apply(1'b1, 1'b1, 1'b0, 1'b1, pls_sample_pkg::SAMPLE_ZERO, pls_sample_pkg::SAMPLE_ZERO);
	for (int k = 0; k < SCR_LEN; k++) begin
		re = rand_sample();
		im = rand_sample();
		if (k % 50 == 7) re = MOST_NEG; // wrap case.
		if (k % 50 == 31) im = MOST_NEG;
		scr_re[k] = re;
		scr_im[k] = im;
		apply(1'b1, 1'b0, 1'b1, 1'b1, re, im);
	end
endtask

task automatic test_pass_gaps();
	apply(1'b1, 1'b1, 1'b0, 1'b1, pls_sample_pkg::SAMPLE_ZERO, pls_sample_pkg::SAMPLE_ZERO);
	repeat (40) apply(1'b1, 1'b0, 1'b1, 1'b1, rand_sample(), rand_sample());
	repeat (10) apply(1'b1, 1'b0, 1'b0, 1'b1, rand_sample(), rand_sample());
	repeat (40) apply(1'b1, 1'b0, 1'b1, 1'b1, rand_sample(), rand_sample());
endtask

// idle cycles drive junk, including init_vld, that must be ignored.
task automatic test_enable_gaps();
	apply(1'b1, 1'b1, 1'b0, 1'b1, pls_sample_pkg::SAMPLE_ZERO, pls_sample_pkg::SAMPLE_ZERO);
	for (int k = 0; k < SCR_LEN; k++) begin
		repeat (2) apply(1'b0, 1'b1, 1'($random(seed)), 1'b0, rand_sample(), rand_sample());
		apply(1'b1, 1'b0, 1'b1, 1'b1, scr_re[k], scr_im[k]);
	end
endtask

task automatic test_reinit();
	apply(1'b1, 1'b1, 1'b0, 1'b1, pls_sample_pkg::SAMPLE_ZERO, pls_sample_pkg::SAMPLE_ZERO);
	repeat (60) apply(1'b1, 1'b0, 1'b1, 1'b1, rand_sample(), rand_sample());
	apply(1'b1, 1'b1, 1'b0, 1'b1, rand_sample(), rand_sample());
	repeat (30) apply(1'b1, 1'b0, 1'b1, 1'b1, rand_sample(), rand_sample());
	apply(1'b1, 1'b1, 1'b1, 1'b1, rand_sample(), rand_sample()); // init with a scrambled sample.
	repeat (30) apply(1'b1, 1'b0, 1'b1, 1'b1, rand_sample(), rand_sample());
endtask

`default_nettype wire
`endif

//--- sim/tb_pls_scrambler.sv
`timescale 1ns/100ps
`default_nettype none

module tb_pls_scrambler;

	localparam pls_code_pkg::lfsr_t X_SEED = pls_code_pkg::X_SEED_DEFAULT;
	localparam int RESET_CYCLES = 16;
	localparam int SCR_LEN = 300;
	// cycles of each test, in run order.
	localparam int TEST_CYCLES = RESET_CYCLES + 20 + 20 + (SCR_LEN + 10) + 100
		+ 3 * (SCR_LEN + 10) + 140;
	localparam int MAX_CYCLES = 2 * TEST_CYCLES;
	localparam pls_sample_pkg::sample_t MOST_NEG = 16'sh8000;

	logic                    sys_clk = 1'b0;
	logic                    rst_n;
	logic                    fs_en;
	logic                    init_vld;
	logic                    scrambler_vld;
	logic                    frame_vld;
	pls_sample_pkg::sample_t re_in;
	pls_sample_pkg::sample_t im_in;
	logic                    oe;
	pls_sample_pkg::sample_t symbol_re_out;
	pls_sample_pkg::sample_t symbol_im_out;

	integer seed;
	int     cycle_cnt = 0;
	int     sample_errs;
	int     code_errs;
	int     oe_errs;
	int     other_errs;

	// gold-code model registers.
	pls_code_pkg::lfsr_t model_x;
	pls_code_pkg::lfsr_t model_y;

	// samples in flight, oldest first.
	pls_sample_pkg::sample_t q_re[$];
	pls_sample_pkg::sample_t q_im[$];
	logic                    q_scr[$];
	logic                    q_frame[$];
	pls_code_pkg::code_t     q_code[$];

	// outputs after the last tick.
	pls_sample_pkg::sample_t last_re;
	pls_sample_pkg::sample_t last_im;
	logic                    last_oe;

	// test 3 samples, replayed with enable gaps.
	pls_sample_pkg::sample_t scr_re[SCR_LEN];
	pls_sample_pkg::sample_t scr_im[SCR_LEN];

	pls_scrambler_top #(
		.X_SEED(X_SEED)
	) uut (
		.sys_clk      (sys_clk),
		.rst_n        (rst_n),
		.fs_en        (fs_en),
		.init_vld     (init_vld),
		.scrambler_vld(scrambler_vld),
		.frame_vld    (frame_vld),
		.re_in        (re_in),
		.im_in        (im_in),
		.oe           (oe),
		.symbol_re_out(symbol_re_out),
		.symbol_im_out(symbol_im_out)
	);

	always #50 sys_clk = ~sys_clk; // 100 ns period.

	always @(posedge sys_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("timeout after %0d cycles, the test sequence did not finish", cycle_cnt);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	initial begin
		seed          = 20855;
		sample_errs   = 0;
		code_errs     = 0;
		oe_errs       = 0;
		other_errs    = 0;
		rst_n         = 1'b0;
		fs_en         = 1'b0;
		init_vld      = 1'b0;
		scrambler_vld = 1'b0;
		frame_vld     = 1'b0;
		re_in         = pls_sample_pkg::SAMPLE_ZERO;
		im_in         = pls_sample_pkg::SAMPLE_ZERO;
		reset_model();

		repeat (RESET_CYCLES) @(negedge sys_clk);
		rst_n = 1'b1;

		test_reset();
		test_latency();
		test_scramble();
		test_pass_gaps();
		test_enable_gaps();
		test_reinit();
		repeat (2) apply(1'b1, 1'b0, 1'b0, 1'b0, pls_sample_pkg::SAMPLE_ZERO,
			pls_sample_pkg::SAMPLE_ZERO); // flush the last samples.

		$display("errors: sample %0d, code %0d, oe %0d, other %0d",
			sample_errs, code_errs, oe_errs, other_errs);
		if (sample_errs + code_errs + oe_errs + other_errs == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	`include "pls_tb_checks.svh"

endmodule

`default_nettype wire

//--- src/pls_code_gen.sv
`timescale 1ns/100ps
`default_nettype none

module pls_code_gen #(
	parameter pls_code_pkg::lfsr_t X_SEED = pls_code_pkg::X_SEED_DEFAULT
) (
	input  wire logic                sys_clk,
	input  wire logic                rst_n,
	input  wire logic                fs_en,
	input  wire logic                init_vld,
	input  wire logic                scrambler_vld,
	output pls_code_pkg::code_t      code
);

	pls_code_pkg::lfsr_t x;
	pls_code_pkg::lfsr_t y;
	logic                scr_vld_d1;
	logic                rn0;
	logic                rn1;

	// rn from the current, pre-shift state.
	assign rn0 = x[0] ^ y[0];
	assign rn1 = (x[4] ^ x[6] ^ x[15]) ^ (y[5] ^ y[6] ^ y[8] ^ (^y[15:9]));

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			x <= '0;
			y <= '0;
		end else if (fs_en) begin
			if (init_vld) begin // init wins over advancing.
				x <= X_SEED;
				y <= pls_code_pkg::Y_LOAD;
			end else if (scr_vld_d1) begin
				x <= {x[0] ^ x[7], x[17:1]};
				y <= {y[0] ^ y[5] ^ y[7] ^ y[10], y[17:1]};
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			scr_vld_d1 <= 1'b0;
		end else if (fs_en) begin
			scr_vld_d1 <= scrambler_vld;
		end
	end

	// code holds until the next scrambled sample needs one.
	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			code <= pls_code_pkg::CODE_PASS;
		end else if (fs_en && scr_vld_d1) begin
			code <= {rn1, rn0};
		end
	end

	// once loaded, y never falls into the all-zero lock-up state.
	a_y_nonzero : assert property (
		@(posedge sys_clk) disable iff (!rst_n)
		($past(rst_n) && $past(y) != '0) |-> (y != '0)
	);

	// code only moves on a tick that consumes a scrambled sample.
	a_code_hold : assert property (
		@(posedge sys_clk) disable iff (!rst_n)
		!(fs_en && scr_vld_d1) |=> $stable(code)
	);

endmodule

`default_nettype wire

//--- src/pls_code_pkg.sv
`default_nettype none

package pls_code_pkg;

	localparam int LFSR_W = 18;

	// state of one gold-code shift register.
	typedef logic [LFSR_W-1:0] lfsr_t;

	// scrambling code rn, selects the quadrant.
	typedef logic [1:0] code_t;

	localparam lfsr_t Y_LOAD = '1;             // y register, all ones.
	localparam lfsr_t X_SEED_DEFAULT = 18'd1;  // x register, gold code 0.

	// code meanings, output as (re, im).
	localparam code_t CODE_PASS  = 2'd0; // (re, im).
	localparam code_t CODE_J     = 2'd1; // (-im, re).
	localparam code_t CODE_NEG   = 2'd2; // (-re, -im).
	localparam code_t CODE_NEG_J = 2'd3; // (im, -re).

endpackage

`default_nettype wire

//--- src/pls_rotator.sv
`timescale 1ns/100ps
`default_nettype none

module pls_rotator (
	input  wire logic                    sys_clk,
	input  wire logic                    rst_n,
	input  wire logic                    fs_en,
	input  wire logic                    scr_vld_d2,
	input  wire logic                    frame_vld_d2,
	input  wire pls_code_pkg::code_t     code,
	input  wire pls_sample_pkg::sample_t re_d2,
	input  wire pls_sample_pkg::sample_t im_d2,
	output logic                         oe,
	output pls_sample_pkg::sample_t      symbol_re_out,
	output pls_sample_pkg::sample_t      symbol_im_out
);

	pls_sample_pkg::sample_t re_rot;
	pls_sample_pkg::sample_t im_rot;

	// quadrant rotation, swap and negate only.
	always_comb begin
		case (code)
			pls_code_pkg::CODE_J: begin
				re_rot = pls_sample_pkg::neg(im_d2);
				im_rot = re_d2;
			end
			pls_code_pkg::CODE_NEG: begin
				re_rot = pls_sample_pkg::neg(re_d2);
				im_rot = pls_sample_pkg::neg(im_d2);
			end
			pls_code_pkg::CODE_NEG_J: begin
				re_rot = im_d2;
				im_rot = pls_sample_pkg::neg(re_d2);
			end
			default: begin // pass.
				re_rot = re_d2;
				im_rot = im_d2;
			end
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			symbol_re_out <= pls_sample_pkg::SAMPLE_ZERO;
			symbol_im_out <= pls_sample_pkg::SAMPLE_ZERO;
		end else if (fs_en) begin
			if (scr_vld_d2) begin
				symbol_re_out <= re_rot;
				symbol_im_out <= im_rot;
			end else begin // unscrambled sample.
				symbol_re_out <= re_d2;
				symbol_im_out <= im_d2;
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			oe <= 1'b0;
		end else if (fs_en) begin
			oe <= frame_vld_d2; // third stage of the frame flag.
		end
	end

	a_oe_reset : assert property (
		@(posedge sys_clk)
		!rst_n |=> !oe
	);

endmodule

`default_nettype wire

//--- src/pls_sample_align.sv
`timescale 1ns/100ps
`default_nettype none

module pls_sample_align (
	input  wire logic                    sys_clk,
	input  wire logic                    rst_n,
	input  wire logic                    fs_en,
	input  wire logic                    scrambler_vld,
	input  wire logic                    frame_vld,
	input  wire pls_sample_pkg::sample_t re_in,
	input  wire pls_sample_pkg::sample_t im_in,
	output logic                         scr_vld_d2,
	output logic                         frame_vld_d2,
	output pls_sample_pkg::sample_t      re_d2,
	output pls_sample_pkg::sample_t      im_d2
);

	logic                    scr_vld_d1;
	logic                    frame_vld_d1;
	pls_sample_pkg::sample_t re_d1;
	pls_sample_pkg::sample_t im_d1;

	// two ticks, so each sample lines up with its code.
	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			scr_vld_d1   <= 1'b0;
			frame_vld_d1 <= 1'b0;
			re_d1        <= pls_sample_pkg::SAMPLE_ZERO;
			im_d1        <= pls_sample_pkg::SAMPLE_ZERO;
			scr_vld_d2   <= 1'b0;
			frame_vld_d2 <= 1'b0;
			re_d2        <= pls_sample_pkg::SAMPLE_ZERO;
			im_d2        <= pls_sample_pkg::SAMPLE_ZERO;
		end else if (fs_en) begin
			scr_vld_d1   <= scrambler_vld;
			frame_vld_d1 <= frame_vld;
			re_d1        <= re_in;
			im_d1        <= im_in;
			scr_vld_d2   <= scr_vld_d1;
			frame_vld_d2 <= frame_vld_d1;
			re_d2        <= re_d1;
			im_d2        <= im_d1;
		end
	end

	a_hold_no_en : assert property (
		@(posedge sys_clk) disable iff (!rst_n)
		!fs_en |=> $stable({scr_vld_d2, frame_vld_d2, re_d2, im_d2})
	);

endmodule

`default_nettype wire

//--- src/pls_sample_pkg.sv
`default_nettype none

package pls_sample_pkg;

	// one I or Q component, signed.
	localparam int SAMPLE_W = 16;

	typedef logic signed [SAMPLE_W-1:0] sample_t;

	localparam sample_t SAMPLE_ZERO = '0; // reset value of sample registers.

	// two's complement negate, wraps so the most negative value maps to itself.
	function automatic sample_t neg(input sample_t v);
		sample_t r;
		r = sample_t'(-v);
		return r;
	endfunction

endpackage

`default_nettype wire

//--- src/pls_scrambler_top.sv
`timescale 1ns/100ps
`default_nettype none

module pls_scrambler_top #(
	parameter pls_code_pkg::lfsr_t X_SEED = pls_code_pkg::X_SEED_DEFAULT
) (
	input  wire logic                    sys_clk,
	input  wire logic                    rst_n,
	input  wire logic                    fs_en,
	input  wire logic                    init_vld,
	input  wire logic                    scrambler_vld,
	input  wire logic                    frame_vld,
	input  wire pls_sample_pkg::sample_t re_in,
	input  wire pls_sample_pkg::sample_t im_in,
	output logic                         oe,
	output pls_sample_pkg::sample_t      symbol_re_out,
	output pls_sample_pkg::sample_t      symbol_im_out
);

	pls_code_pkg::code_t     code;
	logic                    scr_vld_d2;
	logic                    frame_vld_d2;
	pls_sample_pkg::sample_t re_d2;
	pls_sample_pkg::sample_t im_d2;

	pls_code_gen #(
		.X_SEED(X_SEED)
	) u_code_gen (
		.sys_clk      (sys_clk),
		.rst_n        (rst_n),
		.fs_en        (fs_en),
		.init_vld     (init_vld),
		.scrambler_vld(scrambler_vld),
		.code         (code)
	);

	pls_sample_align u_sample_align (
		.sys_clk      (sys_clk),
		.rst_n        (rst_n),
		.fs_en        (fs_en),
		.scrambler_vld(scrambler_vld),
		.frame_vld    (frame_vld),
		.re_in        (re_in),
		.im_in        (im_in),
		.scr_vld_d2   (scr_vld_d2),
		.frame_vld_d2 (frame_vld_d2),
		.re_d2        (re_d2),
		.im_d2        (im_d2)
	);

	pls_rotator u_rotator (
		.sys_clk      (sys_clk),
		.rst_n        (rst_n),
		.fs_en        (fs_en),
		.scr_vld_d2   (scr_vld_d2),
		.frame_vld_d2 (frame_vld_d2),
		.code         (code),
		.re_d2        (re_d2),
		.im_d2        (im_d2),
		.oe           (oe),
		.symbol_re_out(symbol_re_out),
		.symbol_im_out(symbol_im_out)
	);

endmodule

`default_nettype wire
